// ==== sim.f ====
+incdir+hw
hw/nnDataPkg.sv
hw/nnCtrlPkg.sv
hw/inputQueue.sv
hw/layerControl.sv
hw/neuronUnit.sv
hw/denseLayer.sv
verification/denseLayerTb.sv

// ==== Bender.yml ====
package:
  name: dense_layer

sources:
  - include_dirs:
      - hw
    files:
      - hw/nnDataPkg.sv
      - hw/nnCtrlPkg.sv
      - hw/inputQueue.sv
      - hw/layerControl.sv
      - hw/neuronUnit.sv
      - hw/denseLayer.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/denseLayerTb.sv

// ==== verification/denseLayerTb.sv ====
`include "nnMacros.svh"

module denseLayerTb;
	timeunit 1ns;
	timeprecision 100ps;

	import nnDataPkg::*;

	localparam int entryCount = 24;
	localparam int stallLimit = 200; // cycles without progress.

	logic clk;
	logic reset;
	logic inValid;
	sampleT inSample;
	logic inCredit;
	logic outValid;
	resultT outResult;
	logic outCredit;

	string names [entryCount];
	sampleT samples [entryCount];
	resultT expected [entryCount];

	logic [31:0] lfsrState;
	int valueErrors;
	int protocolErrors;
	int granted;
	int heldCredits;
	int sendIdx;
	int sendIdle;
	int received;
	int returned;
	int owed;
	int countdown;
	int sinkCycle;
	int sinkIdle;

	denseLayer DUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inSample(inSample),
		.inCredit(inCredit),
		.outValid(outValid),
		.outResult(outResult),
		.outCredit(outCredit)
	);

	always #50 clk = ~clk;

	// galois lfsr, one step per bit.
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int b = 0; b < count; b++)
		begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
		end
		return bits;
	endfunction

	// ##########################################################################
	// reference model, sign extended products cut back to 16 bits.
	// ##########################################################################
	function automatic resultT modelLayer(input sampleT s);
		resultT r;
		logic [31:0] product;
		logic [15:0] total;
		for (int n = 0; n < `NN_NODES; n++)
		begin
			total = biasTable[n];
			for (int i = 0; i < `NN_INPUTS; i++)
			begin
				product = {{16{s.act[i][15]}}, s.act[i]} *
					{{16{weightTable[n][i][15]}}, weightTable[n][i]};
				total = total + product[15:0];
			end
			r.node[n] = total[15] ? 16'h0000 : total;
		end
		return r;
	endfunction

	task automatic buildTable();
		names[0] = "allZero";
		samples[0] = '0;
		names[1] = "largeNegative";
		samples[1] = '0;
		samples[1].act[8] = 16'd500; // node 0 weight is -59 here.
		names[2] = "productWrap";
		samples[2] = '0;
		samples[2].act[13] = 16'h7fff;
		samples[2].act[5] = 16'h4000;
		for (int e = 3; e < entryCount; e++)
		begin
			names[e] = $sformatf("random%0d", e);
			for (int i = 0; i < `NN_INPUTS; i++)
				samples[e].act[i] = activationT'(randomBits(`NN_DATA_WIDTH));
		end
		for (int e = 0; e < entryCount; e++)
			expected[e] = modelLayer(samples[e]);
	endtask

	task automatic checkGrant();
		granted = 0;
		for (int c = 0; c < 8; c++)
		begin
			@(posedge clk);
			if (inCredit)
				granted++;
			if (outValid)
			begin
				$display("outValid went high before any sample was sent");
				protocolErrors++;
			end
		end
		if (granted != `NN_IN_CREDITS)
		begin
			$display("error initialGrant: expected %0d, actual %0d", `NN_IN_CREDITS, granted);
			valueErrors++;
		end
	endtask

	// ##########################################################################
	// producer sends whenever it holds a credit.
	// ##########################################################################
	task automatic runProducer();
		heldCredits = granted;
		sendIdx = 0;
		sendIdle = 0;
		while (sendIdx < entryCount && sendIdle < stallLimit)
		begin
			@(posedge clk);
			if (inCredit)
				heldCredits++;
			if (heldCredits > `NN_IN_CREDITS)
			begin
				$display("producer holds %0d credits, more than the queue depth", heldCredits);
				protocolErrors++;
			end
			if (heldCredits > 0)
			begin
				inValid <= 1'b1;
				inSample <= samples[sendIdx];
				heldCredits--;
				sendIdx++;
				sendIdle = 0;
			end
			else
			begin
				inValid <= 1'b0;
				sendIdle++;
			end
		end
		@(posedge clk);
		inValid <= 1'b0;
		if (sendIdx < entryCount)
		begin
			$display("producer timed out waiting for an input credit");
			protocolErrors++;
		end
	endtask

	task automatic runSink();
		received = 0;
		returned = 0;
		owed = 0;
		countdown = 0;
		sinkCycle = 0;
		sinkIdle = 0;
		while (received < entryCount && sinkIdle < stallLimit)
		begin
			@(posedge clk);
			sinkCycle++;
			sinkIdle++;
			if (outValid)
			begin
				if (outResult != expected[received])
				begin
					$display("error %s: expected %h, actual %h", names[received],
						expected[received], outResult);
					valueErrors++;
				end
				received++;
				owed++;
				sinkIdle = 0;
			end
			if (received > returned + `NN_OUT_CREDITS)
			begin
				$display("layer sent %0d results with only %0d credits returned", received,
					returned);
				protocolErrors++;
			end
			if (sinkCycle >= 15 && sinkCycle < 45)
				outCredit <= 1'b0; // withhold everything.
			else if (owed > 0 && countdown == 0)
			begin
				outCredit <= 1'b1;
				owed--;
				returned++;
				countdown = randomBits(3);
			end
			else
			begin
				outCredit <= 1'b0;
				if (countdown > 0)
					countdown--;
			end
		end
		if (received < entryCount)
		begin
			$display("sink timed out with %0d of %0d results", received, entryCount);
			protocolErrors++;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		inSample = '0;
		outCredit = 1'b0;
		lfsrState = 32'hc288_79b0;
		valueErrors = 0;
		protocolErrors = 0;
		buildTable();
		if (expected[0].node[0] != 16'd2)
		begin
			$display("error allZeroModel: expected %h, actual %h", 16'd2, expected[0].node[0]);
			valueErrors++;
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		checkGrant();
		fork
			runProducer();
			runSink();
		join
		outCredit <= 1'b0;
		for (int c = 0; c < 10; c++)
		begin
			@(posedge clk);
			if (outValid)
			begin
				$display("extra result appeared after the last expected one");
				protocolErrors++;
			end
		end
		$display("value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== hw/denseLayer.sv ====
`include "nnMacros.svh"

module denseLayer (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnDataPkg::sampleT inSample,
	output logic inCredit,
	output logic outValid,
	output nnDataPkg::resultT outResult,
	input logic outCredit
);
	import nnDataPkg::*;

	sampleT headSample;
	logic notEmpty;
	logic pop;
	logic issue;
	logic creditReturn;
	logic [`NN_NODES-1:0] nodeValid;
	activationT nodeResult [`NN_NODES];

	inputQueue queue (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inSample(inSample),
		.pop(pop),
		.notEmpty(notEmpty),
		.headSample(headSample),
		.creditReturn(creditReturn)
	);

	layerControl control (
		.clk(clk),
		.reset(reset),
		.notEmpty(notEmpty),
		.creditReturn(creditReturn),
		.outCredit(outCredit),
		.pop(pop),
		.issue(issue),
		.inCredit(inCredit)
	);

	for (genvar n = 0; n < `NN_NODES; n++)
	begin : genNode
		neuronUnit #(.nodeIndex(n)) node (
			.clk(clk),
			.reset(reset),
			.issue(issue),
			.sample(headSample),
			.resultValid(nodeValid[n]),
			.result(nodeResult[n])
		);
	end

	assign outValid = nodeValid[0]; // all neurons run in lockstep.

	always_comb
	begin
		for (int n = 0; n < `NN_NODES; n++)
			outResult.node[n] = nodeResult[n];
	end

endmodule

// ==== hw/neuronUnit.sv ====
`include "nnMacros.svh"

module neuronUnit #(
	parameter int nodeIndex = 0
) (
	input logic clk,
	input logic reset,
	input logic issue,
	input nnDataPkg::sampleT sample,
	output logic resultValid,
	output nnDataPkg::activationT result
);
	import nnDataPkg::*;

	sampleT sampleReg;
	activationT sumReg;
	logic sampleValid;
	logic sumValid;

	// products and sum both wrap at 16 bits.
	function automatic activationT weightedSum(input sampleT s);
		activationT acc;
		activationT product;
		acc = biasTable[nodeIndex];
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			product = s.act[i] * weightTable[nodeIndex][i];
			acc = acc + product;
		end
		return acc;
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sampleValid <= 1'b0;
			sumValid <= 1'b0;
			resultValid <= 1'b0;
			sampleReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			sampleValid <= issue;
			sumValid <= sampleValid;
			resultValid <= sumValid;
			if (issue)
				sampleReg <= sample;
			if (sampleValid)
				sumReg <= weightedSum(sampleReg);
			if (sumValid)
				result <= sumReg[`NN_DATA_WIDTH-1] ? '0 : sumReg; // relu.
		end
	end

endmodule

// ==== hw/layerControl.sv ====
`include "nnMacros.svh"

module layerControl (
	input logic clk,
	input logic reset,
	input logic notEmpty,
	input logic creditReturn,
	input logic outCredit,
	output logic pop,
	output logic issue,
	output logic inCredit
);
	import nnCtrlPkg::*;

	layerStateT state;
	creditT grantCount;
	creditT outCredits;

	// a sample leaves the queue only with a result slot already paid for.
	assign pop = notEmpty && (outCredits != '0);
	assign issue = pop;

	// ##########################################################################
	// input credits.
	// ##########################################################################
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stGrant;
			grantCount <= '0;
			inCredit <= 1'b0;
		end
		else
		begin
			case (state)
				stGrant:
				begin
					inCredit <= 1'b1; // one pulse per queue slot.
					grantCount <= grantCount + 1'b1;
					if (grantCount == creditT'(`NN_IN_CREDITS - 1))
						state <= stRun;
				end
				default:
					inCredit <= creditReturn;
			endcase
		end
	end

	// ##########################################################################
	// output credits.
	// ##########################################################################
	always_ff @(posedge clk)
	begin
		if (reset)
			outCredits <= creditT'(`NN_OUT_CREDITS);
		else
		begin
			case ({issue, outCredit})
				2'b10: outCredits <= outCredits - 1'b1;
				2'b01: outCredits <= outCredits + 1'b1;
				default: outCredits <= outCredits; // spend and refund cancel.
			endcase
		end
	end

	// consumer never returns more slots than it owns.
	assert property (@(posedge clk) disable iff (reset)
		(outCredit && !issue) |-> outCredits < creditT'(`NN_OUT_CREDITS));

	// the queue only pops once all initial credits are out.
	assert property (@(posedge clk) disable iff (reset)
		state == stGrant |-> !creditReturn);

endmodule

// ==== hw/inputQueue.sv ====
`include "nnMacros.svh"

module inputQueue (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnDataPkg::sampleT inSample,
	input logic pop,
	output logic notEmpty,
	output nnDataPkg::sampleT headSample,
	output logic creditReturn
);
	import nnDataPkg::*;
	import nnCtrlPkg::*;

	localparam int depth = `NN_IN_CREDITS;
	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;

	sampleT mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	creditT fill;

	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign notEmpty = (fill != '0);
	assign headSample = mem[rdPtr]; // head is visible before the pop.

	always_ff @(posedge clk)
	begin
		if (inValid)
			mem[wrPtr] <= inSample;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			creditReturn <= 1'b0;
		end
		else
		begin
			if (inValid)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			creditReturn <= pop; // one credit back per freed slot.
			case ({inValid, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// producer holds no credit for a full queue.
	assert property (@(posedge clk) disable iff (reset)
		inValid |-> fill < creditT'(depth));

	assert property (@(posedge clk) disable iff (reset)
		pop |-> notEmpty);

endmodule

// ==== hw/nnCtrlPkg.sv ====
`include "nnMacros.svh"

package nnCtrlPkg;

	typedef enum logic {
		stGrant, // handing out the initial input credits.
		stRun
	} layerStateT;

	// sized for the larger of the two credit counts.
	localparam int creditMax = (`NN_IN_CREDITS > `NN_OUT_CREDITS) ?
		`NN_IN_CREDITS : `NN_OUT_CREDITS;

	typedef logic [$clog2(creditMax + 1)-1:0] creditT;

endpackage

// ==== hw/nnDataPkg.sv ====
`include "nnMacros.svh"

package nnDataPkg;

	typedef logic [`NN_DATA_WIDTH-1:0] activationT;

	typedef struct packed {
		activationT [`NN_INPUTS-1:0] act;
	} sampleT;

	typedef struct packed {
		activationT [`NN_NODES-1:0] node;
	} resultT;

	// ##########################################################################
	// fixed weights, node by input. negatives wrap to two's complement.
	// ##########################################################################
	localparam activationT weightTable [`NN_NODES][`NN_INPUTS] = '{
		'{1, 8, 18, -28, 8, 18, -9, -24, -59, 25, 39, -24, -22, 49, 18},
		'{12, -3, 7, 22, -15, 4, 9, -11, 30, -6, 2, 17, -20, 5, -8},
		'{-4, 14, -19, 3, 27, -12, 6, 10, -2, -33, 21, 8, -7, 16, -25},
		'{5, -9, 11, -17, 2, 40, -13, 7, 19, -5, -28, 3, 24, -10, 6}
	};

	localparam activationT biasTable [`NN_NODES] = '{2, -5, 13, -1};

endpackage

// ==== hw/nnMacros.svh ====
`ifndef NN_MACROS_SVH
`define NN_MACROS_SVH

// ##########################################################################
// layer sizes.
// ##########################################################################
`define NN_DATA_WIDTH 16
`define NN_INPUTS 15
`define NN_NODES 4

// ##########################################################################
// credit depths on both sides.
// ##########################################################################
`define NN_IN_CREDITS 2
`define NN_OUT_CREDITS 3

`endif
